// File: flist.f
hdl/video_pkg.sv
hdl/color_pkg.sv
hdl/video_timing.sv
hdl/palette_write_fsm.sv
hdl/layer_mixer.sv
hdl/palette_ram.sv
hdl/system86_video.sv
sim/video_checker.sv
sim/tb_system86_video.sv

// File: hdl/color_pkg.sv
package color_pkg;

	////////////////////////////////////////
	// Color index and RGB
	////////////////////////////////////////

	// 256 palette entries
	localparam int COLOR_INDEX_W = 8;
	// 4 bits per gun
	localparam int CHANNEL_W = 4;

	// Palette address, zero means transparent
	typedef logic [COLOR_INDEX_W-1:0] color_index_t;

	// 12-bit palette entry
	typedef struct packed {
		logic [CHANNEL_W-1:0] red;
		logic [CHANNEL_W-1:0] green;
		logic [CHANNEL_W-1:0] blue;
	} rgb444_t;

	////////////////////////////////////////
	// Layer and host bundles
	////////////////////////////////////////

	// One index per layer for the current pixel
	typedef struct packed {
		color_index_t bg;
		color_index_t fg;
		color_index_t text;
	} layer_pixels_t;

	// Host palette write payload
	typedef struct packed {
		color_index_t addr;
		rgb444_t      color;
	} pal_wr_t;

endpackage

// File: hdl/layer_mixer.sv
`timescale 1ns/1ns

module layer_mixer #(
	parameter logic [2:0] BG_PRIORITY   = 3'd1,
	parameter logic [2:0] FG_PRIORITY   = 3'd2,
	parameter logic [2:0] TEXT_PRIORITY = 3'd3
) (
	input  logic                     clk_48m,
	input  logic                     rst_n,
	input  logic                     pix_en,
	input  color_pkg::layer_pixels_t layers,
	output color_pkg::color_index_t  index
);
	import color_pkg::*;

	color_index_t win_index;
	logic [2:0]   win_pri;

	////////////////////////////////////////
	// Priority resolve
	////////////////////////////////////////

	// Walk bg, fg, text in that order
	// A later layer takes over on >= so ties go upward
	// Transparent layers never compete
	always_comb begin
		win_index = '0;
		win_pri   = '0;

		// Bottom layer
		if (layers.bg != '0) begin
			win_index = layers.bg;
			win_pri   = BG_PRIORITY;
		end

		// Middle layer
		if ((layers.fg != '0) && (FG_PRIORITY >= win_pri)) begin
			win_index = layers.fg;
			win_pri   = FG_PRIORITY;
		end

		// Text over everything on a tie
		if ((layers.text != '0) && (TEXT_PRIORITY >= win_pri)) begin
			win_index = layers.text;
			win_pri   = TEXT_PRIORITY;
		end
		// All clear leaves index 0, the backdrop
	end

	// One pixel stage
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			index <= '0;
		end else if (pix_en) begin
			index <= win_index;
		end
	end

	// Any opaque input must reach the palette stage
	a_opaque_wins: assert property (@(posedge clk_48m) disable iff (!rst_n)
		(pix_en && (layers != '0)) |=> (index != '0))
		else $error("opaque layer lost in mixer");

endmodule

// File: hdl/palette_ram.sv
`timescale 1ns/1ns

module palette_ram (
	input  logic                    clk_48m,
	input  logic                    rst_n,
	input  logic                    pix_en,
	input  color_pkg::color_index_t index,
	input  video_pkg::video_sync_t  sync_in,
	input  logic                    wr_en,
	input  color_pkg::pal_wr_t      wr,
	output color_pkg::rgb444_t      rgb,
	output video_pkg::video_sync_t  sync_out
);
	import video_pkg::*;
	import color_pkg::*;

	localparam int DEPTH = 1 << COLOR_INDEX_W;

	rgb444_t     mem [DEPTH];
	// Sync for the pixel now held in the mixer register
	video_sync_t sync_d1;
	logic        blank;

	////////////////////////////////////////
	// Palette storage
	////////////////////////////////////////

	// Host port, only written during vertical blank
	always_ff @(posedge clk_48m) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.color;
		end
	end

	assign blank = !sync_d1.hblank_n || !sync_d1.vblank_n;

	// Read stage plus matching sync delay
	// Blank forces black on the guns
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			rgb      <= '0;
			sync_d1  <= '1;
			sync_out <= '1;
		end else if (pix_en) begin
			sync_d1  <= sync_in;
			sync_out <= sync_d1;
			rgb      <= blank ? '0 : mem[index];
		end
	end

endmodule

// File: hdl/palette_write_fsm.sv
`timescale 1ns/1ns

module palette_write_fsm (
	input  logic                   clk_48m,
	input  logic                   rst_n,
	input  video_pkg::video_sync_t sync,
	input  logic                   pal_req,
	input  color_pkg::pal_wr_t     pal_wr,
	output logic                   pal_ack,
	output logic                   wr_en,
	output color_pkg::pal_wr_t     wr
);
	import video_pkg::*;
	import color_pkg::*;

	// COMMIT is the single write clock, ack stays up through RELEASE
	typedef enum logic [1:0] {
		IDLE,
		WAIT_BLANK,
		COMMIT,
		RELEASE
	} wr_state_t;

	wr_state_t state;
	wr_state_t state_next;

	////////////////////////////////////////
	// Handshake state machine
	////////////////////////////////////////

	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		unique case (state)
			// Only taken with ack low
			IDLE:       if (pal_req) state_next = WAIT_BLANK;
			// Hold off until the beam is in vertical blank
			WAIT_BLANK: if (!sync.vblank_n) state_next = COMMIT;
			COMMIT:     state_next = RELEASE;
			// Host drops req, then ack follows
			RELEASE:    if (!pal_req) state_next = IDLE;
			default:    state_next = IDLE;
		endcase
	end

	// Payload captured at accept, host may change it after ack
	always_ff @(posedge clk_48m) begin
		if (state == IDLE && pal_req) begin
			wr <= pal_wr;
		end
	end

	assign wr_en   = (state == COMMIT);
	// Ack rises with the write clock
	assign pal_ack = (state == COMMIT) || (state == RELEASE);

	// Blank may end on the clock COMMIT starts
	// Still two pixels ahead of the first visible read
	a_commit_in_vblank: assert property (@(posedge clk_48m) disable iff (!rst_n)
		wr_en |-> (!sync.vblank_n || $rose(sync.vblank_n)))
		else $error("palette write outside vertical blank");

endmodule

// File: hdl/system86_video.sv
`timescale 1ns/1ns

module system86_video #(
	parameter int         PIX_DIV       = 8,
	parameter int         H_ACTIVE      = 288,
	parameter int         H_TOTAL       = 384,
	parameter int         H_SYNC_START  = 304,
	parameter int         H_SYNC_LEN    = 32,
	parameter int         V_ACTIVE      = 224,
	parameter int         V_TOTAL       = 264,
	parameter int         V_SYNC_START  = 240,
	parameter int         V_SYNC_LEN    = 8,
	parameter logic [2:0] BG_PRIORITY   = 3'd1,
	parameter logic [2:0] FG_PRIORITY   = 3'd2,
	parameter logic [2:0] TEXT_PRIORITY = 3'd3
) (
	input  logic                     clk_48m,
	input  logic                     rst_n,
	input  color_pkg::layer_pixels_t layers,
	input  logic                     pal_req,
	input  color_pkg::pal_wr_t       pal_wr,
	output logic                     pal_ack,
	output logic                     pix_en,
	output video_pkg::video_sync_t   sync,
	output color_pkg::rgb444_t       rgb
);
	import video_pkg::*;
	import color_pkg::*;

	// Undelayed sync straight off the counters
	video_sync_t  sync_raw;
	color_index_t mix_index;
	logic         wr_en;
	pal_wr_t      wr_commit;

	////////////////////////////////////////
	// Timing and host write
	////////////////////////////////////////

	// Beam position only feeds the sync decode
	video_timing #(
		.PIX_DIV(PIX_DIV),
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN(H_SYNC_LEN),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_LEN(V_SYNC_LEN)
	) u_timing (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.hcount(),
		.vcount(),
		.sync(sync_raw)
	);

	palette_write_fsm u_pal_wr (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.sync(sync_raw),
		.pal_req(pal_req),
		.pal_wr(pal_wr),
		.pal_ack(pal_ack),
		.wr_en(wr_en),
		.wr(wr_commit)
	);

	////////////////////////////////////////
	// Pixel pipeline
	////////////////////////////////////////

	layer_mixer #(
		.BG_PRIORITY(BG_PRIORITY),
		.FG_PRIORITY(FG_PRIORITY),
		.TEXT_PRIORITY(TEXT_PRIORITY)
	) u_mixer (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.layers(layers),
		.index(mix_index)
	);

	// Sync leaves here aligned with rgb
	palette_ram u_palette (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.index(mix_index),
		.sync_in(sync_raw),
		.wr_en(wr_en),
		.wr(wr_commit),
		.rgb(rgb),
		.sync_out(sync)
	);

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

	////////////////////////////////////////
	// Counter widths
	////////////////////////////////////////

	// Wide enough for 384 clocks per line
	localparam int HCOUNT_W = 9;
	// Wide enough for 264 lines per frame
	localparam int VCOUNT_W = 9;

	// Pixel position along the line
	typedef logic [HCOUNT_W-1:0] hcount_t;
	// Line number within the frame
	typedef logic [VCOUNT_W-1:0] vcount_t;

	////////////////////////////////////////
	// Sync and blank bundle
	////////////////////////////////////////

	// All four are active low
	// Blank low outside the visible area, sync low inside its window
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} video_sync_t;

endpackage

// File: hdl/video_timing.sv
`timescale 1ns/1ns

module video_timing #(
	parameter int PIX_DIV      = 8,
	parameter int H_ACTIVE     = 288,
	parameter int H_TOTAL      = 384,
	parameter int H_SYNC_START = 304,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_ACTIVE     = 224,
	parameter int V_TOTAL      = 264,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_LEN   = 8
) (
	input  logic                   clk_48m,
	input  logic                   rst_n,
	output logic                   pix_en,
	output video_pkg::hcount_t     hcount,
	output video_pkg::vcount_t     vcount,
	output video_pkg::video_sync_t sync
);
	import video_pkg::*;

	// Divider needs at least one bit even for tiny ratios
	localparam int DIV_W      = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC_LEN;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC_LEN;

	logic [DIV_W-1:0] div_cnt;
	logic             h_wrap;
	logic             v_wrap;

	////////////////////////////////////////
	// Pixel enable divider
	////////////////////////////////////////

	// One clk_48m wide pulse every PIX_DIV clocks
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			pix_en  <= 1'b0;
		end else if (div_cnt == DIV_W'(PIX_DIV - 1)) begin
			div_cnt <= '0;
			pix_en  <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			pix_en  <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Beam position counters
	////////////////////////////////////////

	assign h_wrap = (hcount == hcount_t'(H_TOTAL - 1));
	assign v_wrap = (vcount == vcount_t'(V_TOTAL - 1));

	// Line advances once per line wrap
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (pix_en) begin
			if (h_wrap) begin
				hcount <= '0;
				vcount <= v_wrap ? '0 : vcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// Decoded straight from the counters
	always_comb begin
		sync.hblank_n = (hcount < hcount_t'(H_ACTIVE));
		sync.vblank_n = (vcount < vcount_t'(V_ACTIVE));
		sync.hsync_n  = !((hcount >= hcount_t'(H_SYNC_START)) &&
			(hcount < hcount_t'(H_SYNC_END)));
		sync.vsync_n  = !((vcount >= vcount_t'(V_SYNC_START)) &&
			(vcount < vcount_t'(V_SYNC_END)));
	end

	// Wrap must happen exactly at the last pixel
	a_hcount_range: assert property (@(posedge clk_48m) disable iff (!rst_n)
		hcount < hcount_t'(H_TOTAL))
		else $error("hcount reached H_TOTAL");

	// Pulse shape, holds for PIX_DIV of 2 and up
	a_pix_en_pulse: assert property (@(posedge clk_48m) disable iff (!rst_n)
		pix_en |=> !pix_en)
		else $error("pix_en wider than one clock");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the System 86 video testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_system86_video -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_system86_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0

// File: sim/tb_system86_video.sv
`timescale 1ns/1ns

module tb_system86_video;
	import video_pkg::*;
	import color_pkg::*;

	// Small raster so a frame is only a few hundred clocks
	localparam int PIX_DIV    = 2;
	localparam int H_TOTAL    = 12;
	localparam int V_TOTAL    = 8;
	localparam int FRAME_CLKS = PIX_DIV * H_TOTAL * V_TOTAL;
	localparam int N_RANDOM   = 4;

	typedef logic [8*16-1:0] name_t;

	// One table row
	// win is the index the mixer should pick
	typedef struct packed {
		name_t        name;
		color_index_t bg;
		color_index_t fg;
		color_index_t text;
		color_index_t win;
	} row_t;

	logic          clk_48m;
	logic          rst_n;
	layer_pixels_t layers;
	logic          pal_req;
	pal_wr_t       pal_wr;
	logic          pal_ack;
	logic          pix_en;
	video_sync_t   sync;
	rgb444_t       rgb;
	logic          check_en;
	logic          row_done;
	logic          report;
	name_t         cur_name;
	rgb444_t       cur_rgb;
	int            tests_failed;
	row_t          rows[$];
	logic [15:0]   lfsr = 16'd84;
	int            cycle_count = 0;
	int            cycle_limit = 0;

	system86_video #(
		.PIX_DIV(PIX_DIV),
		.H_ACTIVE(8),
		.H_TOTAL(H_TOTAL),
		.H_SYNC_START(9),
		.H_SYNC_LEN(2),
		.V_ACTIVE(4),
		.V_TOTAL(V_TOTAL),
		.V_SYNC_START(5),
		.V_SYNC_LEN(1)
	) DUT (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.layers(layers),
		.pal_req(pal_req),
		.pal_wr(pal_wr),
		.pal_ack(pal_ack),
		.pix_en(pix_en),
		.sync(sync),
		.rgb(rgb)
	);

	video_checker #(
		.V_TOTAL(V_TOTAL),
		.PIX_DIV(PIX_DIV)
	) u_checker (
		.clk_48m(clk_48m),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.sync(sync),
		.rgb(rgb),
		.pal_req(pal_req),
		.pal_ack(pal_ack),
		.check_en(check_en),
		.row_done(row_done),
		.report(report),
		.test_name(cur_name),
		.expected_rgb(cur_rgb),
		.tests_failed(tests_failed)
	);

	initial begin
		clk_48m = 1'b0;
		forever #20 clk_48m = ~clk_48m;
	end

	// Run limit is set once the table is known
	always @(posedge clk_48m) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: no result after %0d clock cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Palette contents are the low 12 bits of index times 0x1F3
	function automatic rgb444_t color_rule(input color_index_t idx);
		logic [19:0] prod;
		prod = 20'(idx) * 20'h1F3;
		return rgb444_t'(prod[11:0]);
	endfunction

	// Taps x^16 + x^14 + x^13 + x^11
	// One step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic color_index_t random_index();
		color_index_t idx;
		idx = '0;
		for (int b = 0; b < 8; b++) idx = {idx[6:0], lfsr_bit()};
		return idx;
	endfunction

	task automatic add_row(input name_t name, input color_index_t bg, input color_index_t fg,
		input color_index_t text, input color_index_t win);
		rows.push_back('{name, bg, fg, text, win});
	endtask

	// Four-phase host write
	task automatic write_entry(input color_index_t idx);
		@(posedge clk_48m);
		#2;
		pal_wr.addr  = idx;
		pal_wr.color = color_rule(idx);
		pal_req      = 1'b1;
		do @(posedge clk_48m); while (!pal_ack);
		#2 pal_req = 1'b0;
		do @(posedge clk_48m); while (pal_ack);
	endtask

	// Returns on the first blank pixel after a line
	// active tells whether that line was visible
	task automatic wait_line_end(output logic active);
		do @(posedge clk_48m); while (!sync.hblank_n);
		do @(posedge clk_48m); while (sync.hblank_n);
		active = sync.vblank_n;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		color_index_t idx;
		name_t        name;
		logic         active;

		rst_n    = 1'b0;
		layers   = '0;
		pal_req  = 1'b0;
		pal_wr   = '0;
		check_en = 1'b0;
		row_done = 1'b0;
		report   = 1'b0;
		cur_name = '0;
		cur_rgb  = '0;

		// name, bg, fg, text, expected winner
		add_row("all_opaque", 8'h11, 8'h22, 8'h33, 8'h33);
		add_row("text_clear", 8'h11, 8'h22, 8'h00, 8'h22);
		add_row("fg_clear", 8'h11, 8'h00, 8'h33, 8'h33);
		add_row("bg_only", 8'h11, 8'h00, 8'h00, 8'h11);
		add_row("fg_only", 8'h00, 8'h22, 8'h00, 8'h22);
		add_row("text_only", 8'h00, 8'h00, 8'h33, 8'h33);
		add_row("text_over_bg", 8'h44, 8'h00, 8'h55, 8'h55);
		add_row("fg_over_bg", 8'h66, 8'h77, 8'h00, 8'h77);
		add_row("all_clear", 8'h00, 8'h00, 8'h00, 8'h00);
		for (int i = 0; i < N_RANDOM; i++) begin
			idx        = random_index();
			name       = "random_0";
			name[7:0]  = 8'h30 + 8'(i);
			add_row(name, idx, 8'h00, 8'h00, idx);
		end

		// Two frames per row plus two per palette write
		cycle_limit = rows.size() * 2 * FRAME_CLKS + (rows.size() + 1) * 2 * FRAME_CLKS + 20;

		repeat (5) @(posedge clk_48m);
		#2 rst_n = 1'b1;

		// Backdrop first, then every winner in the table
		write_entry(8'h00);
		foreach (rows[i]) write_entry(rows[i].win);

		wait_line_end(active);
		foreach (rows[i]) begin
			@(posedge clk_48m);
			#2;
			row_done    = 1'b0;
			cur_name    = rows[i].name;
			cur_rgb     = color_rule(rows[i].win);
			layers.bg   = rows[i].bg;
			layers.fg   = rows[i].fg;
			layers.text = rows[i].text;
			check_en    = 1'b1;
			// Hold until one whole visible line has gone out
			do wait_line_end(active); while (!active);
			#2 row_done = 1'b1;
		end
		@(posedge clk_48m);
		#2;
		row_done = 1'b0;
		check_en = 1'b0;
		report   = 1'b1;
		@(posedge clk_48m);
		#2 report = 1'b0;
		@(posedge clk_48m);

		if (tests_failed == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sim/video_checker.sv
`timescale 1ns/1ns

module video_checker #(
	parameter int V_TOTAL = 264,
	parameter int PIX_DIV = 8
) (
	input  logic                   clk_48m,
	input  logic                   rst_n,
	input  logic                   pix_en,
	input  video_pkg::video_sync_t sync,
	input  color_pkg::rgb444_t     rgb,
	input  logic                   pal_req,
	input  logic                   pal_ack,
	input  logic                   check_en,
	input  logic                   row_done,
	input  logic                   report,
	input  logic [8*16-1:0]        test_name,
	input  color_pkg::rgb444_t     expected_rgb,
	output int                     tests_failed
);
	import video_pkg::*;
	import color_pkg::*;

	int      tests_run = 0;
	int      fails = 0;
	logic    reset_seen = 1'b0;
	// Handshake tracking
	logic    ack_q = 1'b0;
	int      ack_rises = 0;
	int      ack_wait = 0;
	int      hs_bad = 0;
	// Pixel enable spacing
	int      pix_gap = 0;
	int      pix_pulses = 0;
	int      pix_bad = 0;
	int      bad_gap = 0;
	// Per row pixel compare
	int      row_pix = 0;
	int      row_bad = 0;
	rgb444_t bad_rgb;
	// Blanking and sync counts
	int      blank_pix = 0;
	int      blank_bad = 0;
	rgb444_t blank_rgb;
	logic    hs_q = 1'b1;
	logic    vs_q = 1'b1;
	logic    vs_seen = 1'b0;
	int      hs_count = 0;
	int      frames = 0;
	int      bad_frames = 0;
	int      bad_hs = 0;

	assign tests_failed = fails;

	always @(posedge clk_48m) begin
		// First clock out of reset
		if (rst_n && !reset_seen) begin
			reset_seen = 1'b1;
			tests_run++;
			if (rgb != '0 || pal_ack || !sync.hsync_n || !sync.vsync_n) begin
				fails++;
				$display("error reset_state: expected rgb 000 ack 0 hsync_n 1 vsync_n 1, %s",
					$sformatf("actual rgb %h ack %b hsync_n %b vsync_n %b",
					rgb, pal_ack, sync.hsync_n, sync.vsync_n));
			end else begin
				$display("pass reset_state");
			end
		end

		////////////////////////////////////////
		// Handshake
		////////////////////////////////////////

		// Port vblank lags the raw counters by the pixel pipeline
		// so a rise may lead the port blank by up to two pixels
		if (rst_n && pal_ack && !ack_q) begin
			ack_rises++;
			if (sync.vblank_n) ack_wait = 3 * PIX_DIV;
		end else if (ack_wait > 0) begin
			if (!sync.vblank_n) begin
				ack_wait = 0;
			end else if (ack_wait == 1) begin
				hs_bad++;
				ack_wait = 0;
			end else begin
				ack_wait--;
			end
		end
		// Ack may only drop once req is gone
		if (rst_n && !pal_ack && ack_q && pal_req) hs_bad++;
		ack_q = pal_ack;

		////////////////////////////////////////
		// Pixel enable spacing
		////////////////////////////////////////

		// One pulse every PIX_DIV clocks once the divider runs
		if (rst_n) begin
			if (pix_en) begin
				if (pix_pulses > 0 && pix_gap != PIX_DIV) begin
					if (pix_bad == 0) bad_gap = pix_gap;
					pix_bad++;
				end
				pix_pulses++;
				pix_gap = 1;
			end else begin
				pix_gap++;
			end
		end

		////////////////////////////////////////
		// Pixel samples
		////////////////////////////////////////

		if (rst_n && pix_en) begin
			if (!sync.hblank_n || !sync.vblank_n) begin
				blank_pix++;
				if (rgb != '0) begin
					if (blank_bad == 0) blank_rgb = rgb;
					blank_bad++;
				end
			end else if (check_en) begin
				row_pix++;
				if (rgb != expected_rgb) begin
					if (row_bad == 0) bad_rgb = rgb;
					row_bad++;
				end
			end
			// Count hsync falls between vsync falls
			if (!sync.hsync_n && hs_q) hs_count++;
			if (!sync.vsync_n && vs_q) begin
				if (vs_seen) begin
					frames++;
					if (hs_count != V_TOTAL) begin
						if (bad_frames == 0) bad_hs = hs_count;
						bad_frames++;
					end
				end
				vs_seen = 1'b1;
				hs_count = 0;
			end
			hs_q = sync.hsync_n;
			vs_q = sync.vsync_n;
		end

		// One table row finished
		if (row_done) begin
			tests_run++;
			if (row_pix == 0) begin
				fails++;
				$display("error %0s: no visible pixels were compared", test_name);
			end else if (row_bad != 0) begin
				fails++;
				$display("error %0s: expected %h, actual %h", test_name, expected_rgb, bad_rgb);
			end else begin
				$display("pass %0s (%0d pixels)", test_name, row_pix);
			end
			row_pix = 0;
			row_bad = 0;
		end

		////////////////////////////////////////
		// Closing tests and counts
		////////////////////////////////////////

		if (report) begin
			tests_run += 4;
			if (ack_rises == 0 || hs_bad != 0) begin
				fails++;
				$display("error handshake: %0d of %0d acks out of order or outside vblank",
					hs_bad, ack_rises);
			end else begin
				$display("pass handshake (%0d writes)", ack_rises);
			end
			if (pix_pulses < 2) begin
				fails++;
				$display("error pixel_enable: pix_en pulsed fewer than two times");
			end else if (pix_bad != 0) begin
				fails++;
				$display("error pixel_enable: expected %0d, actual %0d", PIX_DIV, bad_gap);
			end else begin
				$display("pass pixel_enable (%0d pulses)", pix_pulses);
			end
			if (blank_pix == 0) begin
				fails++;
				$display("error blanking: no blanked pixels were seen");
			end else if (blank_bad != 0) begin
				fails++;
				$display("error blanking: expected 000, actual %h", blank_rgb);
			end else begin
				$display("pass blanking (%0d pixels)", blank_pix);
			end
			if (frames == 0) begin
				fails++;
				$display("error frame_sync: no complete frame between two vsync pulses");
			end else if (bad_frames != 0) begin
				fails++;
				$display("error frame_sync: expected %0d, actual %0d", V_TOTAL, bad_hs);
			end else begin
				$display("pass frame_sync (%0d frames)", frames);
			end
			$display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - fails, fails);
		end
	end

endmodule
